// ==== source/quant_sa_pkg.sv ====
`default_nettype none

package quant_sa_pkg;

  //////////////////////////////
  // pixel and weight side
  //////////////////////////////

  // one unsigned activation byte
  typedef logic [7:0] pixel_t;
  // two pixels, high pixel in the upper byte
  typedef logic [15:0] pixel_pair_t;
  // signed quantized weight
  typedef logic signed [7:0] weight_t;

  // bit position of the high lane inside the packed operand
  localparam int LANE_SHIFT = 24;

  // one pixel lane after splitting
  typedef logic signed [LANE_SHIFT-1:0] lane_t;
  // two lanes packed, low lane in the bottom LANE_SHIFT bits
  typedef logic signed [2*LANE_SHIFT-1:0] acc_t;
  // packed pixel pair, msb always zero so it reads as positive
  typedef logic [LANE_SHIFT+8:0] op_a_t;

  //////////////////////////////
  // multiplier mode
  //////////////////////////////

  typedef logic signed [15:0] mult_e_t;
  typedef logic signed [23:0] mult_sum_t;
  // full product of sum and E
  typedef logic signed [39:0] mult_p_t;

endpackage

`default_nettype wire

// ==== source/sa_feed_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface sa_feed_if #(
  parameter int ROWS = 4,
  parameter int COLS = 4
);
  import quant_sa_pkg::*;

  // packed pixel pairs enter the top of each column
  op_a_t     [COLS-1:0] a_op;
  // weights enter the left of each row
  weight_t   [ROWS-1:0] b_op;
  // row 0 multiplier operands
  mult_e_t   [COLS-1:0] e_op;
  mult_sum_t [COLS-1:0] sum_op;
  // wave starts for cell (0,0)
  logic en;
  logic out_en;
  logic clear;
  logic mult_mode;

  modport packer (output a_op, b_op, e_op, sum_op, en, out_en, clear, mult_mode);
  modport grid   (input  a_op, b_op, e_op, sum_op, en, out_en, clear, mult_mode);

endinterface

`default_nettype wire

// ==== source/operand_packer.sv ====
`timescale 1ns/1ps
`default_nettype none

module operand_packer #(
  parameter int ROWS = 4,
  parameter int COLS = 4
) (
  input  wire                                 clk,
  input  wire                                 reset,
  input  wire                                 en_pre,
  input  wire                                 out_en_pre,
  input  wire                                 clear_pre,
  input  wire                                 mult_mode_pre,
  input  wire quant_sa_pkg::weight_t     [ROWS-1:0] weight_row,
  input  wire quant_sa_pkg::pixel_pair_t [COLS-1:0] pixel_col,
  input  wire quant_sa_pkg::mult_e_t     [COLS-1:0] e_in,
  input  wire quant_sa_pkg::mult_sum_t   [COLS-1:0] sum_in,
  sa_feed_if.packer                           feed
);
  import quant_sa_pkg::*;

  // high pixel moved up to the high lane, low pixel stays at bit 0
  function automatic op_a_t pack_pair(pixel_pair_t pp);
    pixel_t hi;
    pixel_t lo;
    hi = pp[15:8];
    lo = pp[7:0];
    return (op_a_t'(hi) << LANE_SHIFT) + op_a_t'(lo);
  endfunction

  // wave starts and mode
  always_ff @(posedge clk) begin
    if (reset) begin
      feed.en        <= 1'b0;
      feed.out_en    <= 1'b0;
      feed.clear     <= 1'b0;
      feed.mult_mode <= 1'b0;
    end else begin
      feed.en        <= en_pre;
      feed.out_en    <= out_en_pre;
      feed.clear     <= clear_pre;
      feed.mult_mode <= mult_mode_pre;
    end
  end

  // operand registers
  always_ff @(posedge clk) begin
    for (int j = 0; j < COLS; j++) begin
      feed.a_op[j]   <= pack_pair(pixel_col[j]);
      // multiplier operands held at zero outside multiplier mode
      feed.e_op[j]   <= mult_mode_pre ? e_in[j] : '0;
      feed.sum_op[j] <= mult_mode_pre ? sum_in[j] : '0;
    end
    for (int i = 0; i < ROWS; i++) begin
      feed.b_op[i] <= weight_row[i];
    end
  end

endmodule

`default_nettype wire

// ==== source/pe_cell.sv ====
`timescale 1ns/1ps
`default_nettype none

module pe_cell (
  input  wire                         clk,
  input  wire                         reset,
  input  wire                         clear_pre,
  input  wire                         en_pre,
  input  wire                         out_en_pre,
  input  wire                         mult_mode,
  input  wire quant_sa_pkg::op_a_t     a_in,
  input  wire quant_sa_pkg::weight_t   b_in,
  input  wire quant_sa_pkg::acc_t      next_out,
  input  wire quant_sa_pkg::mult_e_t   e_in,
  input  wire quant_sa_pkg::mult_sum_t sum_in,
  output quant_sa_pkg::op_a_t          a_out,
  output quant_sa_pkg::weight_t        b_out,
  output logic                        clear_out,
  output logic                        en_out,
  output logic                        out_en_out,
  output quant_sa_pkg::acc_t           out,
  output quant_sa_pkg::mult_p_t        mult_out
);
  import quant_sa_pkg::*;

  acc_t acc;
  acc_t b_ext;
  acc_t prod;

  //////////////////////////////
  // waves and operands, one hop
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      clear_out  <= 1'b0;
      en_out     <= 1'b0;
      out_en_out <= 1'b0;
    end else begin
      clear_out  <= clear_pre;
      en_out     <= en_pre;
      out_en_out <= out_en_pre;
    end
  end

  always_ff @(posedge clk) begin
    a_out <= a_in;
    b_out <= b_in;
  end

  //////////////////////////////
  // packed multiply-accumulate
  //////////////////////////////

  // both pixels times one weight in a single product
  assign b_ext = acc_t'(b_out);
  assign prod  = acc_t'($signed(a_out)) * b_ext;

  // clear wins over the old sum, not over the new product
  always_ff @(posedge clk) begin
    if (reset) begin
      acc <= '0;
    end else if (en_out) begin
      acc <= (clear_out ? '0 : acc) + prod;
    end else if (clear_out) begin
      acc <= '0;
    end
  end

  // load on the out_en wave, otherwise shift up from below
  always_ff @(posedge clk) begin
    out <= out_en_out ? acc : next_out;
  end

  // plain multiplier, only live in row 0
  always_ff @(posedge clk) begin
    if (mult_mode) begin
      mult_out <= sum_in * e_in;
    end
  end

endmodule

`default_nettype wire

// ==== source/systolic_grid.sv ====
`timescale 1ns/1ps
`default_nettype none

module systolic_grid #(
  parameter int ROWS = 4,
  parameter int COLS = 4
) (
  input  wire                                 clk,
  input  wire                                 reset,
  sa_feed_if.grid                             feed,
  output quant_sa_pkg::acc_t    [COLS-1:0]    row0_out,
  output logic                                tail_out_en,
  output quant_sa_pkg::mult_p_t [COLS-1:0]    mult_out
);
  import quant_sa_pkg::*;

  // cell outputs, indexed [row][col]
  op_a_t   a_w      [ROWS][COLS];
  weight_t b_w      [ROWS][COLS];
  acc_t    out_w    [ROWS][COLS];
  mult_p_t mult_w   [ROWS][COLS];
  logic    clear_w  [ROWS][COLS];
  logic    en_w     [ROWS][COLS];
  logic    out_en_w [ROWS][COLS];

  for (genvar i = 0; i < ROWS; i++) begin : g_row
    for (genvar j = 0; j < COLS; j++) begin : g_col
      // clamped neighbor indices, only read when the neighbor exists
      localparam int UP = (i > 0) ? i - 1 : 0;
      localparam int LF = (j > 0) ? j - 1 : 0;
      localparam int DN = (i < ROWS - 1) ? i + 1 : i;

      op_a_t   a_in;
      weight_t b_in;
      acc_t    next_in;
      logic    clear_in;
      logic    en_in;
      logic    out_en_in;

      // pixels go down, weights go right, results go up
      assign a_in    = (i == 0) ? feed.a_op[j] : a_w[UP][j];
      assign b_in    = (j == 0) ? feed.b_op[i] : b_w[i][LF];
      assign next_in = (i == ROWS - 1) ? '0 : out_w[DN][j];

      // waves merge from the left and from above
      assign clear_in  = (i == 0 && j == 0) ? feed.clear :
                         ((i > 0) && clear_w[UP][j]) || ((j > 0) && clear_w[i][LF]);
      assign en_in     = (i == 0 && j == 0) ? feed.en :
                         ((i > 0) && en_w[UP][j]) || ((j > 0) && en_w[i][LF]);
      assign out_en_in = (i == 0 && j == 0) ? feed.out_en :
                         ((i > 0) && out_en_w[UP][j]) || ((j > 0) && out_en_w[i][LF]);

      pe_cell i_pe_cell (
        .clk        (clk),
        .reset      (reset),
        .clear_pre  (clear_in),
        .en_pre     (en_in),
        .out_en_pre (out_en_in),
        .mult_mode  ((i == 0) && feed.mult_mode),
        .a_in       (a_in),
        .b_in       (b_in),
        .next_out   (next_in),
        .e_in       ((i == 0) ? feed.e_op[j] : '0),
        .sum_in     ((i == 0) ? feed.sum_op[j] : '0),
        .a_out      (a_w[i][j]),
        .b_out      (b_w[i][j]),
        .clear_out  (clear_w[i][j]),
        .en_out     (en_w[i][j]),
        .out_en_out (out_en_w[i][j]),
        .out        (out_w[i][j]),
        .mult_out   (mult_w[i][j])
      );
    end
  end

  // row 0 result register
  always_ff @(posedge clk) begin
    for (int j = 0; j < COLS; j++) begin
      row0_out[j] <= out_w[0][j];
    end
  end

  always_comb begin
    for (int j = 0; j < COLS; j++) begin
      mult_out[j] = mult_w[0][j];
    end
  end

  // last column sees out_en latest, aligner keys off it
  assign tail_out_en = out_en_w[0][COLS-1];

endmodule

`default_nettype wire

// ==== source/result_aligner.sv ====
`timescale 1ns/1ps
`default_nettype none

module result_aligner #(
  parameter int ROWS = 4,
  parameter int COLS = 4
) (
  input  wire                              clk,
  input  wire                              reset,
  input  wire quant_sa_pkg::acc_t [COLS-1:0] row_in,
  input  wire                              tail_out_en,
  output quant_sa_pkg::acc_t      [COLS-1:0] row_aligned,
  output logic                             row_valid
);
  import quant_sa_pkg::*;

  localparam int CNT_W = $clog2(2 * ROWS + 2);

  logic [CNT_W-1:0] slot_cnt;

  // early columns wait for the last one
  for (genvar j = 0; j < COLS; j++) begin : g_col
    localparam int DEPTH = COLS - 1 - j;
    if (DEPTH == 0) begin : g_direct
      assign row_aligned[j] = row_in[j];
    end else begin : g_delay
      acc_t dly [DEPTH];
      always_ff @(posedge clk) begin
        dly[0] <= row_in[j];
        for (int d = 1; d < DEPTH; d++) begin
          dly[d] <= dly[d-1];
        end
      end
      assign row_aligned[j] = dly[DEPTH-1];
    end
  end

  // tail wave leads the aligned row 0 by two cycles
  // one spare count, then a pulse on every even value
  always_ff @(posedge clk) begin
    if (reset) begin
      slot_cnt <= '0;
    end else if (tail_out_en) begin
      slot_cnt <= CNT_W'(2 * ROWS + 1);
    end else if (slot_cnt != '0) begin
      slot_cnt <= slot_cnt - 1'b1;
    end
  end

  // odd slots hold stale chain values
  assign row_valid = (slot_cnt != '0) && !slot_cnt[0];

endmodule

`default_nettype wire

// ==== source/lane_splitter.sv ====
`timescale 1ns/1ps
`default_nettype none

module lane_splitter #(
  parameter int COLS = 4
) (
  input  wire                              clk,
  input  wire                              reset,
  input  wire quant_sa_pkg::acc_t [COLS-1:0] row_aligned,
  input  wire                              row_valid,
  output quant_sa_pkg::lane_t   [2*COLS-1:0] result,
  output logic                             result_valid
);
  import quant_sa_pkg::*;

  // bottom lane read as signed
  function automatic lane_t lo_lane(acc_t acc);
    return lane_t'(acc[LANE_SHIFT-1:0]);
  endfunction

  // a negative low lane borrowed one from the high lane
  function automatic lane_t hi_lane(acc_t acc);
    lane_t hi;
    hi = lane_t'(acc >>> LANE_SHIFT);
    return hi + lane_t'(acc[LANE_SHIFT-1]);
  endfunction

  always_ff @(posedge clk) begin
    if (reset) begin
      result_valid <= 1'b0;
    end else begin
      result_valid <= row_valid;
    end
  end

  // even slot low pixel, odd slot high pixel
  always_ff @(posedge clk) begin
    for (int j = 0; j < COLS; j++) begin
      result[2*j]   <= lo_lane(row_aligned[j]);
      result[2*j+1] <= hi_lane(row_aligned[j]);
    end
  end

endmodule

`default_nettype wire

// ==== source/quant_sa_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module quant_sa_top #(
  parameter int ROWS = 4,
  parameter int COLS = 4
) (
  input  wire                                    clk,
  input  wire                                    reset,
  input  wire                                    en_pre,
  input  wire                                    out_en_pre,
  input  wire                                    clear_pre,
  input  wire                                    mult_mode,
  input  wire quant_sa_pkg::weight_t     [ROWS-1:0] weight_row,
  input  wire quant_sa_pkg::pixel_pair_t [COLS-1:0] pixel_col,
  input  wire quant_sa_pkg::mult_e_t     [COLS-1:0] e_in,
  input  wire quant_sa_pkg::mult_sum_t   [COLS-1:0] sum_in,
  output quant_sa_pkg::lane_t          [2*COLS-1:0] result,
  output logic                                   result_valid,
  output quant_sa_pkg::mult_p_t          [COLS-1:0] mult_out
);
  import quant_sa_pkg::*;

  acc_t [COLS-1:0] row0_out;
  acc_t [COLS-1:0] row_aligned;
  logic            tail_out_en;
  logic            row_valid;

  sa_feed_if #(.ROWS(ROWS), .COLS(COLS)) feed ();

  //////////////////////////////
  // input side
  //////////////////////////////

  operand_packer #(.ROWS(ROWS), .COLS(COLS)) i_operand_packer (
    .clk           (clk),
    .reset         (reset),
    .en_pre        (en_pre),
    .out_en_pre    (out_en_pre),
    .clear_pre     (clear_pre),
    .mult_mode_pre (mult_mode),
    .weight_row    (weight_row),
    .pixel_col     (pixel_col),
    .e_in          (e_in),
    .sum_in        (sum_in),
    .feed          (feed.packer)
  );

  systolic_grid #(.ROWS(ROWS), .COLS(COLS)) i_systolic_grid (
    .clk         (clk),
    .reset       (reset),
    .feed        (feed.grid),
    .row0_out    (row0_out),
    .tail_out_en (tail_out_en),
    .mult_out    (mult_out)
  );

  //////////////////////////////
  // output side
  //////////////////////////////

  result_aligner #(.ROWS(ROWS), .COLS(COLS)) i_result_aligner (
    .clk         (clk),
    .reset       (reset),
    .row_in      (row0_out),
    .tail_out_en (tail_out_en),
    .row_aligned (row_aligned),
    .row_valid   (row_valid)
  );

  lane_splitter #(.COLS(COLS)) i_lane_splitter (
    .clk          (clk),
    .reset        (reset),
    .row_aligned  (row_aligned),
    .row_valid    (row_valid),
    .result       (result),
    .result_valid (result_valid)
  );

endmodule

`default_nettype wire

// ==== testbench/tb_quant_sa.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_quant_sa;
  import quant_sa_pkg::*;

  localparam int ROWS = 4;
  localparam int COLS = 4;
  localparam int KMAX = 16;
  localparam int NMAX = 8;
  localparam int GOLD_WORDS = 512;
  localparam int RESET_CYCLES = 8;
  // longest wait for all rows of one job
  localparam int COLLECT_LIMIT = 4 * ROWS + 2 * COLS + 8;
  // record kinds in the golden file
  localparam int KIND_END = 0;
  localparam int KIND_MATRIX = 1;
  localparam int KIND_MULT = 2;
  localparam int KIND_IDLE = 3;

  logic clk;
  logic reset;
  logic en_pre;
  logic out_en_pre;
  logic clear_pre;
  logic mult_mode;
  weight_t     [ROWS-1:0]   weight_row;
  pixel_pair_t [COLS-1:0]   pixel_col;
  mult_e_t     [COLS-1:0]   e_in;
  mult_sum_t   [COLS-1:0]   sum_in;
  lane_t       [2*COLS-1:0] result;
  logic                     result_valid;
  mult_p_t     [COLS-1:0]   mult_out;

  // flat word stream from the golden file
  logic [63:0] gold [GOLD_WORDS];
  int gp;
  int test_errors;
  int budget = 0;

  quant_sa_top #(.ROWS(ROWS), .COLS(COLS)) i_quant_sa_top (
    .clk          (clk),
    .reset        (reset),
    .en_pre       (en_pre),
    .out_en_pre   (out_en_pre),
    .clear_pre    (clear_pre),
    .mult_mode    (mult_mode),
    .weight_row   (weight_row),
    .pixel_col    (pixel_col),
    .e_in         (e_in),
    .sum_in       (sum_in),
    .result       (result),
    .result_valid (result_valid),
    .mult_out     (mult_out)
  );

  // 100 ns period
  always #50 clk = ~clk;

  //////////////////////////////
  // helpers
  //////////////////////////////

  function automatic logic [63:0] next_word();
    logic [63:0] w;
    w = gold[gp];
    gp++;
    return w;
  endfunction

  // cycle budget of the whole run from the record layout
  function automatic int cycle_budget();
    int idx;
    int total;
    int kind;
    int len;
    int jobs;
    idx = 0;
    total = RESET_CYCLES;
    kind = int'(gold[0]);
    while (kind != KIND_END && idx < GOLD_WORDS) begin
      if (kind == KIND_MATRIX) begin
        jobs = int'(gold[idx+1]);
        idx += 2;
        for (int n = 0; n < jobs; n++) begin
          len = int'(gold[idx]);
          total += len + 2 * ROWS + COLS + 20;
          idx += 1 + ROWS * len + len * COLS + 2 * ROWS * COLS;
        end
      end else begin
        len = int'(gold[idx+1]);
        total += len + 2 * ROWS + COLS + 20;
        idx += (kind == KIND_MULT) ? 2 + 3 * COLS * len : 2;
      end
      kind = int'(gold[idx]);
    end
    return total;
  endfunction

  function automatic string kind_name(int kind);
    case (kind)
      KIND_MATRIX: return "matrix";
      KIND_MULT:   return "multiplier";
      KIND_IDLE:   return "idle";
      default:     return "unknown";
    endcase
  endfunction

  task automatic clear_inputs();
    en_pre     = 1'b0;
    out_en_pre = 1'b0;
    clear_pre  = 1'b0;
    mult_mode  = 1'b0;
    weight_row = '0;
    pixel_col  = '0;
    e_in       = '0;
    sum_in     = '0;
  endtask

  task automatic apply_reset();
    reset = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    reset = 1'b0;
  endtask

  //////////////////////////////
  // one matrix job
  //////////////////////////////

  task automatic matrix_job();
    int k_len;
    int rows_seen;
    int wait_cycles;
    int extra;
    weight_t     w        [ROWS][KMAX];
    pixel_pair_t p        [KMAX][COLS];
    lane_t       exp_lane [ROWS][2*COLS];
    k_len = int'(next_word());
    for (int i = 0; i < ROWS; i++)
      for (int k = 0; k < k_len; k++)
        w[i][k] = weight_t'(next_word());
    for (int k = 0; k < k_len; k++)
      for (int j = 0; j < COLS; j++)
        p[k][j] = pixel_pair_t'(next_word());
    for (int i = 0; i < ROWS; i++)
      for (int l = 0; l < 2 * COLS; l++)
        exp_lane[i][l] = lane_t'(next_word());

    // skewed streams with row i and column j delayed by i and j cycles
    // out_en right after the last en cycle
    for (int c = 0; c < k_len + ROWS + COLS - 1; c++) begin
      @(posedge clk);
      #1;
      en_pre     = (c < k_len);
      clear_pre  = (c == 0);
      out_en_pre = (c == k_len);
      for (int i = 0; i < ROWS; i++)
        weight_row[i] = (c - i >= 0 && c - i < k_len) ? w[i][c-i] : '0;
      for (int j = 0; j < COLS; j++)
        pixel_col[j] = (c - j >= 0 && c - j < k_len) ? p[c-j][j] : '0;
    end

    // one row per valid pulse in row order
    rows_seen = 0;
    wait_cycles = 0;
    while (rows_seen < ROWS && wait_cycles < COLLECT_LIMIT) begin
      @(negedge clk);
      wait_cycles++;
      if (result_valid) begin
        for (int l = 0; l < 2 * COLS; l++) begin
          assert (result[l] === exp_lane[rows_seen][l]) else begin
            $display("mismatch result[%0d] row %0d: got 0x%06h expected 0x%06h",
                     l, rows_seen, result[l], exp_lane[rows_seen][l]);
            test_errors++;
          end
        end
        rows_seen++;
      end
    end
    assert (rows_seen == ROWS) else begin
      $display("only %0d of %0d result rows arrived within %0d cycles",
               rows_seen, ROWS, COLLECT_LIMIT);
      test_errors++;
    end

    // no pulse beyond the last row
    extra = 0;
    repeat (2 * ROWS + COLS) begin
      @(negedge clk);
      if (result_valid) begin
        extra++;
      end
    end
    assert (extra == 0) else begin
      $display("result_valid rose %0d extra times after the last row", extra);
      test_errors++;
    end
  endtask

  //////////////////////////////
  // multiplier mode and idle
  //////////////////////////////

  task automatic multiplier_check();
    int n;
    mult_e_t   e_v [NMAX][COLS];
    mult_sum_t s_v [NMAX][COLS];
    mult_p_t   p_v [NMAX][COLS];
    n = int'(next_word());
    for (int v = 0; v < n; v++) begin
      for (int j = 0; j < COLS; j++) begin
        e_v[v][j] = mult_e_t'(next_word());
      end
      for (int j = 0; j < COLS; j++) begin
        s_v[v][j] = mult_sum_t'(next_word());
      end
      for (int j = 0; j < COLS; j++) begin
        p_v[v][j] = mult_p_t'(next_word());
      end
    end
    // one vector per cycle
    // each product due two cycles later
    for (int s = 0; s < n + 2; s++) begin
      @(posedge clk);
      #1;
      mult_mode = 1'b1;
      for (int j = 0; j < COLS; j++) begin
        e_in[j]   = (s < n) ? e_v[s][j] : '0;
        sum_in[j] = (s < n) ? s_v[s][j] : '0;
      end
      @(negedge clk);
      if (s >= 2) begin
        for (int j = 0; j < COLS; j++) begin
          assert (mult_out[j] === p_v[s-2][j]) else begin
            $display("mismatch mult_out[%0d] vector %0d: got 0x%010h expected 0x%010h",
                     j, s - 2, mult_out[j], p_v[s-2][j]);
            test_errors++;
          end
        end
      end
    end
    @(posedge clk);
    #1;
    clear_inputs();
  endtask

  task automatic idle_check();
    int n;
    n = int'(next_word());
    @(posedge clk);
    #1;
    apply_reset();
    for (int c = 0; c < n; c++) begin
      @(negedge clk);
      assert (!result_valid) else begin
        $display("mismatch result_valid %0d cycles after reset: got 0x%0h expected 0x0",
                 c, result_valid);
        test_errors++;
      end
    end
  endtask

  // watchdog
  initial begin
    wait (budget > 0);
    repeat (budget) @(posedge clk);
    $display("timeout: run did not finish within %0d cycles", budget);
    $display("TEST FAIL");
    $finish;
  end

  initial begin
    int kind;
    int jobs;
    int tests_run;
    int tests_failed;
    int errors;
    clk = 1'b0;
    clear_inputs();
    tests_run = 0;
    tests_failed = 0;
    errors = 0;
    gp = 0;
    $readmemh("testbench/golden_quant_sa.txt", gold);
    budget = cycle_budget();
    apply_reset();

    kind = int'(next_word());
    while (kind != KIND_END) begin
      test_errors = 0;
      tests_run++;
      if (kind == KIND_MATRIX) begin
        jobs = int'(next_word());
        repeat (jobs) matrix_job();
      end else if (kind == KIND_MULT) begin
        multiplier_check();
      end else if (kind == KIND_IDLE) begin
        idle_check();
      end else begin
        $display("unknown test kind %0d in golden file", kind);
        errors++;
        tests_failed++;
        break;
      end
      $display("test %0d %s: %s, %0d errors", tests_run, kind_name(kind),
               (test_errors == 0) ? "ok" : "failed", test_errors);
      errors += test_errors;
      if (test_errors != 0) begin
        tests_failed++;
      end
      kind = int'(next_word());
    end

    $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== testbench/golden_quant_sa.txt ====
// kind 1: jobs, per job K, weights w[row][k], pixel pairs p[k][col], lanes per row lo0 hi0 .. hi3
// kind 2: vectors, per vector e[col], sum[col], sum*e[col]; kind 3: idle cycles; kind 0 ends
// test 1 small positive values
1 1
2
01 02
03 01
02 02
01 04
0102 0301 0200 0504
0201 0101 0003 0202
000004 000005 000003 000005 000006 000002 000008 000009
000007 000005 000004 00000a 000003 000006 00000e 000011
000006 000006 000004 000008 000006 000004 00000c 00000e
000006 000009 000005 000007 00000c 000002 00000c 00000d
// test 2 extreme pixels and weights, negative low lanes
1 1
2
80 7f
80 80
7f 7f
7f 80
ffff 00ff ff00 01ff
ffff ff00 00ff ff01
ffff01 ffff01 ff8080 007e81 007e81 ff8080 ff80ff 007e01
ff0100 ff0100 ff8080 ff8080 ff8080 ff8080 ff8000 ff8000
00fd02 00fd02 007e81 007e81 007e81 007e81 007f00 007f00
ffff01 ffff01 007e81 ff8080 ff8080 007e81 007e01 ff80ff
// test 3 two jobs back to back
1 2
2
01 01
02 01
03 01
04 01
0101 0101 0101 0101
0101 0101 0101 0101
000002 000002 000002 000002 000002 000002 000002 000002
000003 000003 000003 000003 000003 000003 000003 000003
000004 000004 000004 000004 000004 000004 000004 000004
000005 000005 000005 000005 000005 000005 000005 000005
2
01 00
01 01
01 02
01 03
0102 0202 0302 0402
0100 0101 0102 0103
000002 000001 000002 000002 000002 000003 000002 000004
000002 000002 000003 000003 000004 000004 000005 000005
000002 000003 000004 000004 000006 000005 000008 000006
000002 000004 000005 000005 000008 000006 00000b 000007
// test 4 multiplier mode
2 3
0003 fffe 0064 ffff
000005 000007 fffffd fffc18
000000000f fffffffff2 fffffffed4 00000003e8
7fff 8000 0000 0002
000002 000001 00007b 800000
000000fffe ffffff8000 0000000000 ffff000000
8000 7fff fffb 0010
800000 7fffff 000004 000010
4000000000 3fff7f8001 ffffffffec 0000000100
// test 5 idle after reset, 0x32 cycles
3 32
0

// ==== files.f ====
source/quant_sa_pkg.sv
source/sa_feed_if.sv
source/operand_packer.sv
source/pe_cell.sv
source/systolic_grid.sv
source/result_aligner.sv
source/lane_splitter.sv
source/quant_sa_top.sv
testbench/tb_quant_sa.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal -j 0
TOP       = tb_quant_sa
FILELIST  = files.f
OBJ_DIR   = obj_dir
SIM_BIN   = $(OBJ_DIR)/V$(TOP)
SOURCES   = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(SIM_BIN)

# rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -q "TEST PASS"

clean:
	rm -rf $(OBJ_DIR)
